//--- logic/sd_reg_pkg.sv
//////////////////////////////////////////////////
// host register map of the CMD path, 16-bit words
// response types other than R1 and R3 send no response
// status bits are plain flags, cleared on command launch
//////////////////////////////////////////////////

package sd_reg_pkg;

   typedef logic [3:0] reg_addr_t;

   //////////////////////////////////////////////////
   // register addresses
   //////////////////////////////////////////////////
   localparam reg_addr_t ADDR_ARG0   = 4'd0;   // argument bits 15:0
   localparam reg_addr_t ADDR_ARG1   = 4'd1;   // argument bits 31:16
   localparam reg_addr_t ADDR_CMD    = 4'd2;   // write starts a command
   localparam reg_addr_t ADDR_RESP0  = 4'd4;
   localparam reg_addr_t ADDR_RESP1  = 4'd5;
   localparam reg_addr_t ADDR_STATUS = 4'd6;

   // command register fields
   localparam int CMD_IDX_LSB   = 0;
   localparam int CMD_IDX_MSB   = 5;
   localparam int CMD_RTYPE_LSB = 8;
   localparam int CMD_RTYPE_MSB = 9;

   typedef enum logic [1:0] {
      RESP_NONE = 2'd0,
      RESP_R1   = 2'd1,
      RESP_R3   = 2'd2
   } resp_type_t;

   // status word bit positions
   localparam int STAT_COMPLETE  = 0;
   localparam int STAT_TIMEOUT   = 1;
   localparam int STAT_CRC_ERR   = 2;
   localparam int STAT_END_ERR   = 3;
   localparam int STAT_INDEX_ERR = 4;
   localparam int STAT_CARD_ERR  = 5;
   localparam int STAT_OCR_READY = 6;

endpackage

//--- logic/sd_frame_pkg.sv
//////////////////////////////////////////////////
// 48-bit CMD line frame format, sent MSB first
// crc7 covers the 40 leading bits, seed zero
//////////////////////////////////////////////////

package sd_frame_pkg;

   localparam int FRAME_BITS = 48;

   localparam logic [5:0] R3_INDEX = 6'h3f;   // R3 carries all ones here

   // x^7 + x^3 + 1, one bit per step
   function automatic logic [6:0] crc7(input logic [39:0] bits);
      logic [6:0] crc;
      logic       fb;
      crc = 7'd0;
      for (int i = 39; i >= 0; i--) begin
         fb     = bits[i] ^ crc[6];
         crc    = {crc[5:0], fb};
         crc[3] = crc[3] ^ fb;
      end
      return crc;
   endfunction

   //////////////////////////////////////////////////
   // payload word, R1 card status or R3 OCR
   //////////////////////////////////////////////////
   typedef struct packed {
      logic       out_of_range;
      logic       address_error;
      logic       block_len_error;
      logic       erase_seq_error;
      logic       erase_param;
      logic       wp_violation;
      logic       card_locked;
      logic       lock_unlock_failed;
      logic       com_crc_error;
      logic       illegal_command;
      logic       card_ecc_failed;
      logic       cc_error;
      logic       general_error;       // bit 19
      logic [5:0] spare_mid;           // 18:13
      logic [3:0] current_state;
      logic       ready_for_data;
      logic [7:0] spare_low;
   } r1_status_t;

   typedef struct packed {
      logic        power_up_done;      // busy bit, high when done
      logic        ccs;
      logic [5:0]  reserved;
      logic [23:0] vdd_window;
   } r3_ocr_t;

   typedef union packed {
      r1_status_t r1;
      r3_ocr_t    ocr;
   } resp_payload_u;

endpackage

//--- logic/sd_reg_decode.sv
//////////////////////////////////////////////////
// host register file, write decode and readback
// command and argument writes are dropped while busy
// readback is combinational on reg_rd_addr
//////////////////////////////////////////////////
`timescale 1ns/100ps

module sd_reg_decode (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  logic                   reg_wr,
   input  sd_reg_pkg::reg_addr_t  reg_addr,
   input  logic [15:0]            reg_wr_data,
   input  sd_reg_pkg::reg_addr_t  reg_rd_addr,
   input  logic                   cmd_busy,
   input  logic [15:0]            resp0,
   input  logic [15:0]            resp1,
   input  logic [15:0]            status,
   output logic [15:0]            reg_rd_data,
   output logic                   new_cmd,
   output logic [5:0]             cmd_index,
   output logic [31:0]            cmd_arg,
   output sd_reg_pkg::resp_type_t resp_type
);
   import sd_reg_pkg::*;

   logic [15:0] arg0_q;
   logic [15:0] arg1_q;
   logic [15:0] cmd_q;
   logic        wr_ok;

   assign wr_ok = reg_wr && !cmd_busy;   // arguments stay stable during a command

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         arg0_q  <= '0;
         arg1_q  <= '0;
         cmd_q   <= '0;
         new_cmd <= 1'b0;
      end else begin
         new_cmd <= wr_ok && (reg_addr == ADDR_CMD);
         if (wr_ok && (reg_addr == ADDR_ARG0)) arg0_q <= reg_wr_data;
         if (wr_ok && (reg_addr == ADDR_ARG1)) arg1_q <= reg_wr_data;
         if (wr_ok && (reg_addr == ADDR_CMD))  cmd_q  <= reg_wr_data;
      end
   end

   assign cmd_index = cmd_q[CMD_IDX_MSB:CMD_IDX_LSB];
   assign cmd_arg   = {arg1_q, arg0_q};
   assign resp_type = resp_type_t'(cmd_q[CMD_RTYPE_MSB:CMD_RTYPE_LSB]);

   //////////////////////////////////////////////////
   // readback mux
   //////////////////////////////////////////////////
   always_comb begin
      case (reg_rd_addr)
         ADDR_ARG0:   reg_rd_data = arg0_q;
         ADDR_ARG1:   reg_rd_data = arg1_q;
         ADDR_CMD:    reg_rd_data = cmd_q;
         ADDR_RESP0:  reg_rd_data = resp0;
         ADDR_RESP1:  reg_rd_data = resp1;
         ADDR_STATUS: reg_rd_data = status;
         default:     reg_rd_data = '0;   // unmapped reads as zero
      endcase
   end

endmodule

//--- logic/sd_cmd_exec.sv
//////////////////////////////////////////////////
// CMD line engine, one line bit per CLK cycle
// needs ncr_min >= 1 and resp_timeout > ncr_min
// no R2, a response is always 48 bits
//////////////////////////////////////////////////
`timescale 1ns/100ps

module sd_cmd_exec #(
   parameter int resp_timeout = 64,
   parameter int ncr_min      = 2
) (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  logic                   new_cmd,
   input  logic [5:0]             cmd_index,
   input  logic [31:0]            cmd_arg,
   input  sd_reg_pkg::resp_type_t resp_type,
   input  logic                   cmd_from_card,
   input  logic                   done_ack,
   output logic                   cmd_to_card,
   output logic                   cmd_to_card_oe,
   output logic                   cmd_busy,
   output logic                   resp_valid,
   output logic [47:0]            resp_frame,
   output logic                   resp_timeout_hit,
   output sd_reg_pkg::resp_type_t resp_type_q,
   output logic [5:0]             exp_index
);
   import sd_reg_pkg::*;
   import sd_frame_pkg::*;

   localparam int CNT_W = $clog2(resp_timeout + FRAME_BITS);

   typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_WAIT, ST_RECV} state_t;

   state_t                state;
   logic [CNT_W-1:0]      cnt;      // bit count in send/recv, idle count in wait
   logic                  busy_q;
   logic [FRAME_BITS-1:0] tx_sr;
   logic [FRAME_BITS-1:0] rx_sr;
   logic [39:0]           frame_head;
   logic                  launch;
   logic                  expect_resp;
   logic                  start_ok;

   assign launch      = new_cmd && (state == ST_IDLE);
   assign frame_head  = {2'b01, cmd_index, cmd_arg};   // start, direction, index, arg
   assign expect_resp = (resp_type_q == RESP_R1) || (resp_type_q == RESP_R3);
   assign start_ok    = (cnt >= CNT_W'(ncr_min)) && !cmd_from_card;

   assign cmd_to_card_oe = (state == ST_SEND);
   assign cmd_to_card    = cmd_to_card_oe ? tx_sr[FRAME_BITS-1] : 1'b1;   // idles high
   assign cmd_busy       = busy_q || new_cmd;
   assign resp_frame     = rx_sr;

   //////////////////////////////////////////////////
   // control FSM
   //////////////////////////////////////////////////
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         state            <= ST_IDLE;
         cnt              <= '0;
         busy_q           <= 1'b0;
         resp_valid       <= 1'b0;
         resp_timeout_hit <= 1'b0;
         resp_type_q      <= RESP_NONE;
         exp_index        <= '0;
      end else begin
         resp_valid       <= 1'b0;
         resp_timeout_hit <= 1'b0;
         if (done_ack) busy_q <= 1'b0;

         case (state)
            ST_IDLE: begin
               if (launch) begin
                  state       <= ST_SEND;
                  cnt         <= '0;
                  busy_q      <= 1'b1;
                  resp_type_q <= resp_type;
                  exp_index   <= cmd_index;
               end
            end
            ST_SEND: begin
               if (cnt == CNT_W'(FRAME_BITS - 1)) begin
                  state <= ST_WAIT;   // end bit is on the line now
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ST_WAIT: begin
               cnt <= cnt + 1'b1;
               if (!expect_resp) begin
                  if (cnt == CNT_W'(ncr_min - 1)) begin
                     resp_valid <= 1'b1;   // no response, zero frame
                     state      <= ST_IDLE;
                  end
               end else if (start_ok) begin
                  state <= ST_RECV;
                  cnt   <= CNT_W'(1);   // start bit already taken
               end else if (cnt == CNT_W'(resp_timeout - 1)) begin
                  resp_timeout_hit <= 1'b1;
                  state            <= ST_IDLE;
               end
            end
            ST_RECV: begin
               if (cnt == CNT_W'(FRAME_BITS - 1)) begin
                  resp_valid <= 1'b1;
                  state      <= ST_IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // shift registers
   //////////////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (launch)
         tx_sr <= {frame_head, crc7(frame_head), 1'b1};
      else if (state == ST_SEND)
         tx_sr <= {tx_sr[FRAME_BITS-2:0], 1'b1};

      if (state == ST_WAIT)
         rx_sr <= '0;   // start bit is a zero too
      else if (state == ST_RECV)
         rx_sr <= {rx_sr[FRAME_BITS-2:0], cmd_from_card};
   end

endmodule

//--- logic/sd_resp_result.sv
//////////////////////////////////////////////////
// response checks and result registers
// R3 skips the CRC check, R1 checks CRC and index
// status is replaced on completion, cleared on launch
//////////////////////////////////////////////////
`timescale 1ns/100ps

module sd_resp_result (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  logic                   resp_valid,
   input  logic [47:0]            resp_frame,
   input  logic                   resp_timeout_hit,
   input  sd_reg_pkg::resp_type_t resp_type_q,
   input  logic [5:0]             exp_index,
   input  logic                   new_cmd,
   output logic [15:0]            resp0,
   output logic [15:0]            resp1,
   output logic [15:0]            status,
   output logic                   cmd_done,
   output logic                   done_ack
);
   import sd_reg_pkg::*;
   import sd_frame_pkg::*;

   resp_payload_u payload;
   logic [15:0]   stat_next;
   logic          card_err;

   assign payload = resp_frame[39:8];

   // any of the thirteen R1 error flags
   assign card_err = payload.r1.out_of_range    | payload.r1.address_error
                   | payload.r1.block_len_error | payload.r1.erase_seq_error
                   | payload.r1.erase_param     | payload.r1.wp_violation
                   | payload.r1.card_locked     | payload.r1.lock_unlock_failed
                   | payload.r1.com_crc_error   | payload.r1.illegal_command
                   | payload.r1.card_ecc_failed | payload.r1.cc_error
                   | payload.r1.general_error;

   //////////////////////////////////////////////////
   // status word for a received frame
   //////////////////////////////////////////////////
   always_comb begin
      stat_next = '0;
      stat_next[STAT_COMPLETE] = 1'b1;
      case (resp_type_q)
         RESP_R1: begin
            stat_next[STAT_CRC_ERR]   = crc7(resp_frame[47:8]) != resp_frame[7:1];
            stat_next[STAT_INDEX_ERR] = resp_frame[45:40] != exp_index;
            stat_next[STAT_END_ERR]   = !resp_frame[0];
            stat_next[STAT_CARD_ERR]  = card_err;
         end
         RESP_R3: begin
            stat_next[STAT_INDEX_ERR] = resp_frame[45:40] != R3_INDEX;   // crc field ignored
            stat_next[STAT_END_ERR]   = !resp_frame[0];
            stat_next[STAT_OCR_READY] = payload.ocr.power_up_done;
         end
         default: ;   // completion only
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         resp0    <= '0;
         resp1    <= '0;
         status   <= '0;
         cmd_done <= 1'b0;
      end else begin
         cmd_done <= resp_valid || resp_timeout_hit;
         if (new_cmd) begin
            status <= '0;
         end else if (resp_timeout_hit) begin
            status <= 16'(1 << STAT_TIMEOUT) | 16'(1 << STAT_COMPLETE);
         end else if (resp_valid) begin
            status <= stat_next;
            if ((resp_type_q == RESP_R1) || (resp_type_q == RESP_R3)) begin
               resp0 <= payload[15:0];
               resp1 <= payload[31:16];
            end
         end
      end
   end

   assign done_ack = cmd_done;   // releases busy in the execute block

endmodule

//--- logic/sd_cmd_host.sv
//////////////////////////////////////////////////
// SD host CMD path, single clock domain
// one CMD line bit per CLK, host polls cmd_busy
//////////////////////////////////////////////////
`timescale 1ns/100ps

module sd_cmd_host #(
   parameter int resp_timeout = 64,
   parameter int ncr_min      = 2
) (
   input  logic                  CLK,
   input  logic                  rst_n,
   input  logic                  reg_wr,
   input  sd_reg_pkg::reg_addr_t reg_addr,
   input  logic [15:0]           reg_wr_data,
   input  sd_reg_pkg::reg_addr_t reg_rd_addr,
   output logic [15:0]           reg_rd_data,
   output logic                  cmd_to_card,
   output logic                  cmd_to_card_oe,
   input  logic                  cmd_from_card,
   output logic                  cmd_busy,
   output logic                  cmd_done
);
   import sd_reg_pkg::*;

   logic        new_cmd;
   logic [5:0]  cmd_index;
   logic [31:0] cmd_arg;
   resp_type_t  resp_type;
   logic        resp_valid;
   logic [47:0] resp_frame;
   logic        resp_timeout_hit;
   resp_type_t  resp_type_q;
   logic [5:0]  exp_index;
   logic        done_ack;
   logic [15:0] resp0;
   logic [15:0] resp1;
   logic [15:0] status;

   sd_reg_decode u_decode (
      .CLK(CLK), .rst_n(rst_n),
      .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wr_data(reg_wr_data),
      .reg_rd_addr(reg_rd_addr), .cmd_busy(cmd_busy),
      .resp0(resp0), .resp1(resp1), .status(status),
      .reg_rd_data(reg_rd_data), .new_cmd(new_cmd),
      .cmd_index(cmd_index), .cmd_arg(cmd_arg), .resp_type(resp_type)
   );

   sd_cmd_exec #(.resp_timeout(resp_timeout), .ncr_min(ncr_min)) u_exec (
      .CLK(CLK), .rst_n(rst_n),
      .new_cmd(new_cmd), .cmd_index(cmd_index), .cmd_arg(cmd_arg),
      .resp_type(resp_type), .cmd_from_card(cmd_from_card), .done_ack(done_ack),
      .cmd_to_card(cmd_to_card), .cmd_to_card_oe(cmd_to_card_oe), .cmd_busy(cmd_busy),
      .resp_valid(resp_valid), .resp_frame(resp_frame),
      .resp_timeout_hit(resp_timeout_hit), .resp_type_q(resp_type_q),
      .exp_index(exp_index)
   );

   sd_resp_result u_result (
      .CLK(CLK), .rst_n(rst_n),
      .resp_valid(resp_valid), .resp_frame(resp_frame),
      .resp_timeout_hit(resp_timeout_hit), .resp_type_q(resp_type_q),
      .exp_index(exp_index), .new_cmd(new_cmd),
      .resp0(resp0), .resp1(resp1), .status(status),
      .cmd_done(cmd_done), .done_ack(done_ack)
   );

endmodule

//--- bench/sd_card_model.sv
//////////////////////////////////////////////////
// behavioral SD card on the CMD line
// answers each captured frame once, after resp_delay CLK
// resp_delay below 3 falls inside the host's Ncr window
//////////////////////////////////////////////////
`timescale 1ns/100ps

module sd_card_model (
   input  logic        CLK,
   input  logic        rst_n,
   input  logic        cmd_to_card,
   input  logic        cmd_to_card_oe,
   output logic        cmd_from_card,
   input  logic [2:0]  action,        // 0 good, 1 bad crc, 2 bad index, 3 bad end, 4 silent
   input  logic        resp_r3,
   input  logic [7:0]  resp_delay,
   input  logic [31:0] resp_payload,
   output int          frame_count,
   output logic [5:0]  cap_index,
   output logic [31:0] cap_arg,
   output logic        cap_crc_ok
);
   import sd_frame_pkg::*;

   logic [47:0] rx;
   logic [47:0] tx;
   logic [5:0]  idx;
   logic [6:0]  crc;

   // shift and xor form of x^7 + x^3 + 1
   function automatic logic [6:0] crc7_calc(input logic [39:0] bits);
      logic [6:0] c;
      logic       msb;
      c = '0;
      for (int i = 39; i >= 0; i--) begin
         msb = c[6] ^ bits[i];
         c   = c << 1;
         if (msb)
            c = c ^ 7'h09;
      end
      return c;
   endfunction

   initial begin
      cmd_from_card = 1'b1;   // line idles high
      frame_count   = 0;
      cap_index     = '0;
      cap_arg       = '0;
      cap_crc_ok    = 1'b0;
      rx            = '0;
      forever begin
         @(negedge CLK);
         if (rst_n && cmd_to_card_oe) begin
            for (int i = 0; i < FRAME_BITS; i++) begin
               rx = {rx[46:0], cmd_to_card};
               if (i < FRAME_BITS - 1)
                  @(negedge CLK);
            end
            cap_index   = rx[45:40];
            cap_arg     = rx[39:8];
            cap_crc_ok  = (rx[7:1] == crc7_calc(rx[47:8])) && (rx[47:46] == 2'b01) && rx[0];
            frame_count = frame_count + 1;

            if (action != 3'd4) begin
               idx = resp_r3 ? R3_INDEX : rx[45:40];   // R1 echoes the index
               if (action == 3'd2)
                  idx = idx ^ 6'h01;
               crc = crc7_calc({2'b00, idx, resp_payload});
               if (resp_r3)
                  crc = ~crc;   // host must ignore it for R3
               else if (action == 3'd1)
                  crc = crc ^ 7'h01;
               tx = {2'b00, idx, resp_payload, crc, action != 3'd3};
               repeat (resp_delay) @(posedge CLK);
               for (int i = FRAME_BITS - 1; i >= 0; i--) begin
                  #1 cmd_from_card = tx[i];
                  @(posedge CLK);
               end
               #1 cmd_from_card = 1'b1;
            end
         end
      end
   end

endmodule

//--- bench/sd_cmd_properties.sv
//////////////////////////////////////////////////
// CMD line timing checks, bound into sd_cmd_exec
//////////////////////////////////////////////////
`timescale 1ns/100ps

module sd_cmd_properties (
   input logic CLK,
   input logic rst_n,
   input logic new_cmd,
   input logic cmd_to_card_oe,
   input logic cmd_busy,
   input logic resp_valid,
   input logic resp_timeout_hit
);
   import sd_frame_pkg::*;

   int   oe_len;    // cycles of the current drive window
   logic pending;   // launched command still waiting for its outcome

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n)
         oe_len <= 0;
      else if (cmd_to_card_oe)
         oe_len <= oe_len + 1;
      else
         oe_len <= 0;
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n)
         pending <= 1'b0;
      else if (new_cmd)
         pending <= 1'b1;
      else if (resp_valid || resp_timeout_hit)
         pending <= 1'b0;
   end

   oe_after_launch: assert property (@(posedge CLK) disable iff (!rst_n)
      new_cmd |=> cmd_to_card_oe)
      else $error("cmd_to_card_oe did not rise the cycle after new_cmd");

   oe_window_len: assert property (@(posedge CLK) disable iff (!rst_n)
      $fell(cmd_to_card_oe) |-> (oe_len == FRAME_BITS))
      else $error("cmd_to_card_oe window is not 48 cycles long");

   oe_means_busy: assert property (@(posedge CLK) disable iff (!rst_n)
      cmd_to_card_oe |-> cmd_busy)
      else $error("cmd_to_card_oe high without cmd_busy");

   single_outcome: assert property (@(posedge CLK) disable iff (!rst_n)
      (resp_valid || resp_timeout_hit) |->
         (pending && !(resp_valid && resp_timeout_hit)))
      else $error("outcome without a pending command, or two outcomes at once");

endmodule

//--- bench/tb_sd_cmd_host.sv
//////////////////////////////////////////////////
// testbench for the SD host CMD path
// card responses come from sd_card_model
// response delays must stay between 3 and resp_timeout
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_sd_cmd_host;
   import sd_reg_pkg::*;

   localparam int RESP_TIMEOUT = 64;
   localparam int NCR_MIN      = 2;
   localparam int NUM_TESTS    = 11;
   localparam int CYCLE_LIMIT  = NUM_TESTS * (96 + RESP_TIMEOUT + 20);

   // card actions
   localparam logic [2:0] GOOD    = 3'd0;
   localparam logic [2:0] BAD_CRC = 3'd1;
   localparam logic [2:0] BAD_IDX = 3'd2;
   localparam logic [2:0] BAD_END = 3'd3;
   localparam logic [2:0] SILENT  = 3'd4;

   typedef struct packed {
      logic [5:0]  index;
      resp_type_t  rtype;
      logic [2:0]  action;
      logic [7:0]  delay;
      logic [31:0] pay_and;
      logic [31:0] pay_or;
      logic [15:0] exp_stat;   // payload flags added per test
      logic        busy_wr;    // second command write while busy
   } test_t;

   test_t tests [NUM_TESTS];

   logic        CLK = 1'b0;
   logic        rst_n;
   logic        reg_wr;
   reg_addr_t   reg_addr;
   logic [15:0] reg_wr_data;
   reg_addr_t   reg_rd_addr;
   logic [15:0] reg_rd_data;
   logic        cmd_to_card;
   logic        cmd_to_card_oe;
   logic        cmd_from_card;
   logic        cmd_busy;
   logic        cmd_done;

   logic [2:0]  card_action;
   logic        card_r3;
   logic [7:0]  card_delay;
   logic [31:0] card_payload;
   int          frame_count;
   logic [5:0]  cap_index;
   logic [31:0] cap_arg;
   logic        cap_crc_ok;

   int          cycles = 0;
   int          errors = 0;
   int          passed = 0;
   int          errs_before;
   int          frames_before;
   logic [15:0] cmd_word;
   logic [31:0] arg;
   logic [31:0] payload;
   logic [31:0] exp_resp;
   logic [15:0] exp_stat;
   logic [15:0] rd;

   always #5 CLK = ~CLK;

   sd_cmd_host #(.resp_timeout(RESP_TIMEOUT), .ncr_min(NCR_MIN)) DUT (
      .CLK(CLK), .rst_n(rst_n),
      .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wr_data(reg_wr_data),
      .reg_rd_addr(reg_rd_addr), .reg_rd_data(reg_rd_data),
      .cmd_to_card(cmd_to_card), .cmd_to_card_oe(cmd_to_card_oe),
      .cmd_from_card(cmd_from_card), .cmd_busy(cmd_busy), .cmd_done(cmd_done)
   );

   sd_card_model card (
      .CLK(CLK), .rst_n(rst_n),
      .cmd_to_card(cmd_to_card), .cmd_to_card_oe(cmd_to_card_oe),
      .cmd_from_card(cmd_from_card), .action(card_action), .resp_r3(card_r3),
      .resp_delay(card_delay), .resp_payload(card_payload),
      .frame_count(frame_count), .cap_index(cap_index), .cap_arg(cap_arg),
      .cap_crc_ok(cap_crc_ok)
   );

   bind sd_cmd_exec sd_cmd_properties u_props (
      .CLK(CLK), .rst_n(rst_n), .new_cmd(new_cmd), .cmd_to_card_oe(cmd_to_card_oe),
      .cmd_busy(cmd_busy), .resp_valid(resp_valid), .resp_timeout_hit(resp_timeout_hit)
   );

   //////////////////////////////////////////////////
   // host bus tasks
   //////////////////////////////////////////////////
   task automatic write_reg(input reg_addr_t addr, input logic [15:0] data);
      @(posedge CLK);
      #1;
      reg_wr      = 1'b1;
      reg_addr    = addr;
      reg_wr_data = data;
      @(posedge CLK);
      #1;
      reg_wr = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output logic [15:0] data);
      @(posedge CLK);
      #1;
      reg_rd_addr = addr;
      @(negedge CLK);   // readback is combinational
      data = reg_rd_data;
   endtask

   task automatic wait_idle();
      @(negedge CLK);
      while (cmd_busy)
         @(negedge CLK);
   endtask

   task automatic wait_done();
      do
         @(negedge CLK);
      while (!cmd_done);
   endtask

   // run limit
   always @(posedge CLK) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: commands did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      rst_n        = 1'b0;
      reg_wr       = 1'b0;
      reg_addr     = '0;
      reg_wr_data  = '0;
      reg_rd_addr  = '0;
      card_action  = SILENT;
      card_r3      = 1'b0;
      card_delay   = 8'd3;
      card_payload = '0;
      exp_resp     = '0;
      void'($urandom(32'h27a9bb52));

      //          index   type       action   dly    and mask       or mask        status    busy
      tests[0]  = '{6'd17, RESP_R1,   GOOD,    8'd3,  32'h0007ffff, 32'h00000000, 16'h0001, 1'b0};
      tests[1]  = '{6'd13, RESP_R1,   GOOD,    8'd6,  32'hffffffff, 32'h00100000, 16'h0001, 1'b0};
      tests[2]  = '{6'd41, RESP_R3,   GOOD,    8'd4,  32'hffffffff, 32'h80000000, 16'h0001, 1'b0};
      tests[3]  = '{6'd41, RESP_R3,   GOOD,    8'd9,  32'h7fffffff, 32'h00000000, 16'h0001, 1'b0};
      tests[4]  = '{6'd8,  RESP_R1,   SILENT,  8'd3,  32'hffffffff, 32'h00000000, 16'h0003, 1'b0};
      tests[5]  = '{6'd0,  RESP_NONE, SILENT,  8'd3,  32'hffffffff, 32'h00000000, 16'h0001, 1'b0};
      tests[6]  = '{6'd24, RESP_R1,   BAD_CRC, 8'd5,  32'hffffffff, 32'h00000000, 16'h0005, 1'b0};
      tests[7]  = '{6'd55, RESP_R1,   BAD_IDX, 8'd3,  32'hffffffff, 32'h00000000, 16'h0011, 1'b0};
      tests[8]  = '{6'd7,  RESP_R1,   BAD_END, 8'd12, 32'hffffffff, 32'h00000000, 16'h0009, 1'b0};
      tests[9]  = '{6'd1,  RESP_R3,   BAD_END, 8'd4,  32'hffffffff, 32'h00000000, 16'h0009, 1'b0};
      tests[10] = '{6'd16, RESP_R1,   GOOD,    8'd3,  32'h0007ffff, 32'h00000000, 16'h0001, 1'b1};

      repeat (10) @(posedge CLK);
      #1 rst_n = 1'b1;

      // idle state out of reset
      read_reg(ADDR_STATUS, rd);
      if (cmd_to_card_oe !== 1'b0 || cmd_to_card !== 1'b1) begin
         $display("Mismatch at %0t: cmd_to_card_oe/cmd_to_card expected 0/1 got %b/%b",
                  $time, cmd_to_card_oe, cmd_to_card);
         errors++;
      end
      if (cmd_busy !== 1'b0 || cmd_done !== 1'b0) begin
         $display("Mismatch at %0t: cmd_busy/cmd_done expected 0/0 got %b/%b",
                  $time, cmd_busy, cmd_done);
         errors++;
      end
      if (rd !== 16'h0000) begin
         $display("Mismatch at %0t: STATUS expected 0000 got %h", $time, rd);
         errors++;
      end
      $display("reset: %0d errors", errors);

      //////////////////////////////////////////////////
      // table loop
      //////////////////////////////////////////////////
      for (int t = 0; t < NUM_TESTS; t++) begin
         errs_before   = errors;
         arg           = $urandom();
         payload       = ($urandom() & tests[t].pay_and) | tests[t].pay_or;
         frames_before = frame_count;
         card_action   = tests[t].action;
         card_r3       = (tests[t].rtype == RESP_R3);
         card_delay    = tests[t].delay;
         card_payload  = payload;
         cmd_word      = {6'd0, tests[t].rtype, 2'b00, tests[t].index};

         // status flags that follow from the payload
         exp_stat = tests[t].exp_stat;
         if (tests[t].action != SILENT) begin
            if (tests[t].rtype == RESP_R1)
               exp_stat[STAT_CARD_ERR] = |payload[31:19];
            if (tests[t].rtype == RESP_R3)
               exp_stat[STAT_OCR_READY] = payload[31];
            if (tests[t].rtype != RESP_NONE)
               exp_resp = payload;
         end

         wait_idle();
         write_reg(ADDR_ARG0, arg[15:0]);
         write_reg(ADDR_ARG1, arg[31:16]);
         write_reg(ADDR_CMD, cmd_word);
         read_reg(ADDR_STATUS, rd);
         if (rd !== 16'h0000) begin
            $display("Mismatch at %0t: STATUS after launch expected 0000 got %h", $time, rd);
            errors++;
         end
         if (tests[t].busy_wr)
            write_reg(ADDR_CMD, {6'd0, RESP_R1, 2'b00, ~tests[t].index});
         wait_done();

         // a write while busy must leave the command register alone
         read_reg(ADDR_CMD, rd);
         if (rd !== cmd_word) begin
            $display("Mismatch at %0t: CMD expected %h got %h", $time, cmd_word, rd);
            errors++;
         end
         read_reg(ADDR_RESP0, rd);
         if (rd !== exp_resp[15:0]) begin
            $display("Mismatch at %0t: RESP0 expected %h got %h", $time, exp_resp[15:0], rd);
            errors++;
         end
         read_reg(ADDR_RESP1, rd);
         if (rd !== exp_resp[31:16]) begin
            $display("Mismatch at %0t: RESP1 expected %h got %h", $time, exp_resp[31:16], rd);
            errors++;
         end
         read_reg(ADDR_STATUS, rd);
         if (rd !== exp_stat) begin
            $display("Mismatch at %0t: STATUS expected %h got %h", $time, exp_stat, rd);
            errors++;
         end
         if (frame_count != frames_before + 1) begin
            $display("card saw %0d command frames in test %0d instead of one",
                     frame_count - frames_before, t);
            errors++;
         end
         if (cap_index !== tests[t].index) begin
            $display("Mismatch at %0t: frame index expected %0d got %0d",
                     $time, tests[t].index, cap_index);
            errors++;
         end
         if (cap_arg !== arg) begin
            $display("Mismatch at %0t: frame argument expected %h got %h", $time, arg, cap_arg);
            errors++;
         end
         if (!cap_crc_ok) begin
            $display("command frame in test %0d has a bad CRC7 or framing bits", t);
            errors++;
         end

         if (errors == errs_before)
            passed++;
         $display("test %0d: cmd %0d type %0d action %0d, %0d errors", t, tests[t].index,
                  tests[t].rtype, tests[t].action, errors - errs_before);
      end

      $display("%0d tests, %0d passed, %0d failed, %0d errors in all",
               NUM_TESTS, passed, NUM_TESTS - passed, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- tb.f
logic/sd_reg_pkg.sv
logic/sd_frame_pkg.sv
logic/sd_reg_decode.sv
logic/sd_cmd_exec.sv
logic/sd_resp_result.sv
logic/sd_cmd_host.sv
bench/sd_card_model.sv
bench/sd_cmd_properties.sv
bench/tb_sd_cmd_host.sv

//--- Makefile
# Verilator build and run of the SD CMD path testbench

VERILATOR ?= verilator
TOP       ?= tb_sd_cmd_host
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
